// File: design/pim_data_pkg.sv
// *********************************************************************
// PIM convolution data types
// Widths of pixels, weights, packed windows, column sums and results
// *********************************************************************
`default_nettype none

package pim_data_pkg;

	localparam int PIXEL_W = 8;
	localparam int TAPS    = 9;

	typedef logic [PIXEL_W-1:0]      pixel_t;
	typedef logic [PIXEL_W-1:0]      weight_t;
	// Element 0 in the low byte
	typedef logic [TAPS*PIXEL_W-1:0] window_t;
	typedef logic [TAPS*PIXEL_W-1:0] kernel_t;
	typedef logic [TAPS-1:0]         plane_t;
	// Peak column sum is 9 * 255 = 2295
	typedef logic [11:0]             colsum_t;
	typedef logic [19:0]             result_t;

endpackage

`default_nettype wire

// File: design/pim_ctrl_pkg.sv
// *********************************************************************
// PIM convolution control types
// Sequencer states, kernel slot address and bit-plane index
// *********************************************************************
`default_nettype none

package pim_ctrl_pkg;

	localparam int PLANES       = 8;
	localparam int KERNEL_SLOTS = 4;

	typedef enum logic [1:0]
	{
		IDLE,
		RUN,
		DONE
	} seq_state_t;

	// Slot count follows from this width
	typedef logic [1:0] kernel_addr_t;
	typedef logic [2:0] bit_idx_t;

endpackage

`default_nettype wire

// File: design/bit_plane_counter.sv
// *********************************************************************
// Bit-plane index counter
// Counts down from the MSB plane, flags the last plane
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

module bit_plane_counter (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic                  load,
	input  wire logic                  count_en,
	output pim_ctrl_pkg::bit_idx_t     bit_idx,
	output logic                       last_plane
);

	assign last_plane = (bit_idx == '0);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			bit_idx <= '0;
		else if (load)
			bit_idx <= pim_ctrl_pkg::bit_idx_t'(pim_ctrl_pkg::PLANES - 1);
		else if (count_en)
			bit_idx <= bit_idx - 1'b1;
	end

endmodule

`default_nettype wire

// File: design/input_bit_slicer.sv
// *********************************************************************
// Input bit slicer
// Holds the pixel window and drives one bit of every pixel per plane
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

module input_bit_slicer (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   load,
	input  wire pim_data_pkg::window_t  window,
	input  wire pim_ctrl_pkg::bit_idx_t bit_idx,
	output pim_data_pkg::plane_t        plane
);

	pim_data_pkg::window_t window_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			window_q <= '0;
		else if (load)
			window_q <= window;
	end

	// Word lines for the current plane
	always_comb
	begin
		pim_data_pkg::pixel_t pix;
		for (int i = 0; i < pim_data_pkg::TAPS; i++)
		begin
			pix      = window_q[i*pim_data_pkg::PIXEL_W +: pim_data_pkg::PIXEL_W];
			plane[i] = pix[bit_idx];
		end
	end

endmodule

`default_nettype wire

// File: design/weight_crossbar.sv
// *********************************************************************
// Weight crossbar with column ADC
// Stores the kernel slots, forms the dot product of one input plane
// with the selected kernel and saturates it to the ADC range
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

module weight_crossbar #(
	parameter int ADC_BITS = 11
) (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire logic                       busy,
	input  wire logic                       wr_en,
	input  wire pim_ctrl_pkg::kernel_addr_t wr_addr,
	input  wire pim_data_pkg::kernel_t      wr_kernel,
	input  wire logic                       load,
	input  wire pim_ctrl_pkg::kernel_addr_t start_addr,
	input  wire pim_data_pkg::plane_t       plane,
	output pim_data_pkg::colsum_t           adc_out
);

	localparam pim_data_pkg::colsum_t ADC_MAX = pim_data_pkg::colsum_t'((1 << ADC_BITS) - 1);

	pim_data_pkg::kernel_t       cells [pim_ctrl_pkg::KERNEL_SLOTS];
	pim_ctrl_pkg::kernel_addr_t  addr_q;
	pim_data_pkg::colsum_t       col_sum;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < pim_ctrl_pkg::KERNEL_SLOTS; s++)
				cells[s] <= '0;
			addr_q <= '0;
		end
		else
		begin
			// Array contents are frozen during a compute
			if (wr_en && !busy)
				cells[wr_addr] <= wr_kernel;
			if (load)
				addr_q <= start_addr;
		end
	end

	always_comb
	begin
		pim_data_pkg::kernel_t kern;
		kern    = cells[addr_q];
		col_sum = '0;
		for (int i = 0; i < pim_data_pkg::TAPS; i++)
			if (plane[i])
				col_sum = col_sum + pim_data_pkg::colsum_t'(
					pim_data_pkg::weight_t'(kern[i*pim_data_pkg::PIXEL_W +: pim_data_pkg::PIXEL_W]));
	end

	assign adc_out = (col_sum > ADC_MAX) ? ADC_MAX : col_sum;

endmodule

`default_nettype wire

// File: design/shift_accumulator.sv
// *********************************************************************
// Shift accumulator
// Combines quantized plane results MSB first by shift and add
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

module shift_accumulator #(
	parameter int ADC_BITS = 11
) (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic                  acc_clear,
	input  wire logic                  acc_en,
	input  wire pim_data_pkg::colsum_t adc_out,
	output pim_data_pkg::result_t      result
);

	// Only the ADC code bits carry information
	logic [ADC_BITS-1:0] code;

	assign code = adc_out[ADC_BITS-1:0];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			result <= '0;
		else if (acc_clear)
			result <= '0;
		else if (acc_en)
			result <= (result << 1) + pim_data_pkg::result_t'(code);
	end

endmodule

`default_nettype wire

// File: design/pim_conv_fsm.sv
// *********************************************************************
// PIM convolution sequencer
// Accepts a start when idle, sweeps the bit planes, then pulses done
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

module pim_conv_fsm (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic start,
	input  wire logic last_plane,
	output logic      load,
	output logic      count_en,
	output logic      acc_clear,
	output logic      acc_en,
	output logic      busy,
	output logic      done
);

	pim_ctrl_pkg::seq_state_t state;
	pim_ctrl_pkg::seq_state_t state_next;

	// Still busy during the done cycle
	assign busy      = (state != pim_ctrl_pkg::IDLE) || done;
	assign load      = start && !busy;
	assign acc_clear = load;
	assign count_en  = (state == pim_ctrl_pkg::RUN);
	assign acc_en    = (state == pim_ctrl_pkg::RUN);

	always_comb
	begin
		state_next = state;
		case (state)
			pim_ctrl_pkg::IDLE: if (load) state_next = pim_ctrl_pkg::RUN;
			pim_ctrl_pkg::RUN:  if (last_plane) state_next = pim_ctrl_pkg::DONE;
			pim_ctrl_pkg::DONE: state_next = pim_ctrl_pkg::IDLE;
			default:            state_next = pim_ctrl_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= pim_ctrl_pkg::IDLE;
			done  <= 1'b0;
		end
		else
		begin
			state <= state_next;
			done  <= (state == pim_ctrl_pkg::DONE);
		end
	end

endmodule

`default_nettype wire

// File: design/pim_conv_top.sv
// *********************************************************************
// PIM 3x3 convolution engine, top level
// Bit-serial compute over eight planes of a pixel window against one
// of four stored kernels, with a saturating ADC per plane
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

module pim_conv_top #(
	parameter int ADC_BITS = 11
) (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire logic                       wr_en,
	input  wire pim_ctrl_pkg::kernel_addr_t wr_addr,
	input  wire pim_data_pkg::kernel_t      wr_kernel,
	input  wire logic                       start,
	input  wire pim_ctrl_pkg::kernel_addr_t start_addr,
	input  wire pim_data_pkg::window_t      window,
	output logic                            busy,
	output logic                            done,
	output pim_data_pkg::result_t           result
);

	logic                      load;
	logic                      count_en;
	logic                      acc_clear;
	logic                      acc_en;
	logic                      last_plane;
	pim_ctrl_pkg::bit_idx_t    bit_idx;
	pim_data_pkg::plane_t      plane;
	pim_data_pkg::colsum_t     adc_out;

	pim_conv_fsm pim_conv_fsm_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.last_plane (last_plane),
		.load       (load),
		.count_en   (count_en),
		.acc_clear  (acc_clear),
		.acc_en     (acc_en),
		.busy       (busy),
		.done       (done)
	);

	bit_plane_counter bit_plane_counter_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.load       (load),
		.count_en   (count_en),
		.bit_idx    (bit_idx),
		.last_plane (last_plane)
	);

	input_bit_slicer input_bit_slicer_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.load    (load),
		.window  (window),
		.bit_idx (bit_idx),
		.plane   (plane)
	);

	weight_crossbar #(
		.ADC_BITS (ADC_BITS)
	) weight_crossbar_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.busy       (busy),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_kernel  (wr_kernel),
		.load       (load),
		.start_addr (start_addr),
		.plane      (plane),
		.adc_out    (adc_out)
	);

	shift_accumulator #(
		.ADC_BITS (ADC_BITS)
	) shift_accumulator_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.acc_clear (acc_clear),
		.acc_en    (acc_en),
		.adc_out   (adc_out),
		.result    (result)
	);

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
// *********************************************************************
// Testbench clock and reset
// 20 ns clock, rst_n held low for the first three rising edges
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#2 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: testbench/pim_conv_sva.sv
// *********************************************************************
// Protocol assertions for the PIM convolution top level
// Reset values, done latency and pulse width, busy during a compute
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

module pim_conv_sva (
	input wire logic                  clk,
	input wire logic                  rst_n,
	input wire logic                  start,
	input wire logic                  busy,
	input wire logic                  done,
	input wire pim_data_pkg::result_t result
);

	// Number of assertion failures so far
	int failures = 0;

	a_reset_values: assert property (@(posedge clk)
		!rst_n |=> (!busy && !done && result == '0))
		else
		begin
			$error("busy, done or result not cleared by reset");
			failures++;
		end

	// One done per accepted start, 9 cycles after the start edge
	a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
		done == $past(start && !busy, 10))
		else
		begin
			$error("done does not follow an accepted start by 9 cycles");
			failures++;
		end

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else
		begin
			$error("done held longer than one cycle");
			failures++;
		end

	a_busy_on_start: assert property (@(posedge clk) disable iff (!rst_n)
		(start && !busy) |=> busy)
		else
		begin
			$error("busy not raised after an accepted start");
			failures++;
		end

	a_busy_until_done: assert property (@(posedge clk) disable iff (!rst_n)
		(busy && !done) |=> busy)
		else
		begin
			$error("busy dropped before done");
			failures++;
		end

endmodule

bind pim_conv_top pim_conv_sva pim_conv_sva_i (
	.clk    (clk),
	.rst_n  (rst_n),
	.start  (start),
	.busy   (busy),
	.done   (done),
	.result (result)
);

`default_nettype wire

// File: testbench/pim_conv_tb.sv
// *********************************************************************
// PIM convolution testbench
// Random and directed computes against a bit-plane reference model,
// checked at every done, with a cycle limit on the whole run
// *********************************************************************
`timescale 1ns/1ns
`default_nettype none

module pim_conv_tb;

	localparam int ADC_BITS = 11;
	// Room for 60 computes plus the kernel writes
	localparam int MAX_CYCLES = 60 * 30 + 200;

	logic                       clk;
	logic                       rst_n;
	logic                       wr_en;
	pim_ctrl_pkg::kernel_addr_t wr_addr;
	pim_data_pkg::kernel_t      wr_kernel;
	logic                       start;
	pim_ctrl_pkg::kernel_addr_t start_addr;
	pim_data_pkg::window_t      window;
	logic                       busy;
	logic                       done;
	pim_data_pkg::result_t      result;

	pim_data_pkg::kernel_t slots [pim_ctrl_pkg::KERNEL_SLOTS];
	integer                seed;
	int                    errors = 0;
	int                    cycles = 0;

	tb_clock_gen tb_clock_gen_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	pim_conv_top pim_conv_top_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_kernel  (wr_kernel),
		.start      (start),
		.start_addr (start_addr),
		.window     (window),
		.busy       (busy),
		.done       (done),
		.result     (result)
	);

	// Sum over planes of 2^b times the clamped column sum
	function automatic pim_data_pkg::result_t expected(input pim_data_pkg::window_t w,
		input pim_data_pkg::kernel_t k);
		pim_data_pkg::result_t acc;
		int                    d;
		int                    pix;
		int                    lim;
		lim = (1 << ADC_BITS) - 1;
		acc = '0;
		for (int b = 0; b < 8; b++)
		begin
			d = 0;
			for (int i = 0; i < 9; i++)
			begin
				pix = int'(w[i*8 +: 8]);
				if (((pix >> b) & 1) == 1)
					d = d + int'(k[i*8 +: 8]);
			end
			if (d > lim)
				d = lim;
			acc = acc + (pim_data_pkg::result_t'(d) << b);
		end
		return acc;
	endfunction

	function automatic pim_data_pkg::window_t random_vec();
		logic [95:0] bits;
		bits = {$random(seed), $random(seed), $random(seed)};
		return bits[71:0];
	endfunction

	task automatic check_value(input string name, input int unsigned act,
		input int unsigned exp);
		assert (act == exp)
		else
		begin
			errors++;
			$display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic wait_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic write_kernel(input pim_ctrl_pkg::kernel_addr_t addr,
		input pim_data_pkg::kernel_t k);
		wr_en     = 1'b1;
		wr_addr   = addr;
		wr_kernel = k;
		slots[addr] = k;
		wait_cycle();
		wr_en = 1'b0;
	endtask

	// poke adds a start and a write to the same slot while busy
	task automatic run_compute(input pim_ctrl_pkg::kernel_addr_t addr,
		input pim_data_pkg::window_t w, input bit poke);
		pim_data_pkg::result_t exp_val;
		int                    lat;
		exp_val    = expected(w, slots[addr]);
		start      = 1'b1;
		start_addr = addr;
		window     = w;
		wait_cycle();
		start = 1'b0;
		lat   = 0;
		while (!done)
		begin
			check_value("busy", 32'(busy), 32'd1);
			if (poke && lat == 3)
			begin
				start      = 1'b1;
				start_addr = ~addr;
				window     = ~w;
				wr_en      = 1'b1;
				wr_addr    = addr;
				wr_kernel  = ~slots[addr];
			end
			else
			begin
				start = 1'b0;
				wr_en = 1'b0;
			end
			wait_cycle();
			lat++;
		end
		check_value("done latency", lat, 9);
		check_value("result", 32'(result), 32'(exp_val));
		wait_cycle();
		check_value("done", 32'(done), 32'd0);
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors: %0d testbench, %0d assertions", errors,
				pim_conv_top_i.pim_conv_sva_i.failures);
			$display("Something failed");
			$finish;
		end
	end

	initial
	begin
		pim_data_pkg::window_t w;
		seed       = 32'h905c9a93;
		wr_en      = 1'b0;
		wr_addr    = '0;
		wr_kernel  = '0;
		start      = 1'b0;
		start_addr = '0;
		window     = '0;
		for (int s = 0; s < pim_ctrl_pkg::KERNEL_SLOTS; s++)
			slots[s] = '0;

		while (rst_n !== 1'b1)
			@(posedge clk);
		#2;
		check_value("busy", 32'(busy), 32'd0);
		check_value("done", 32'(done), 32'd0);
		check_value("result", 32'(result), 32'd0);

		for (int s = 0; s < pim_ctrl_pkg::KERNEL_SLOTS; s++)
			write_kernel(pim_ctrl_pkg::kernel_addr_t'(s), random_vec());
		repeat (40)
			run_compute(pim_ctrl_pkg::kernel_addr_t'($random(seed)), random_vec(), 1'b0);

		// Every plane saturates the ADC
		write_kernel(2'd0, {9{8'hff}});
		run_compute(2'd0, {9{8'hff}}, 1'b0);
		check_value("result", 32'(result), 2047 * 255);

		// Start and write while busy, then reuse the slot
		w = random_vec();
		run_compute(2'd1, w, 1'b1);
		run_compute(2'd1, w, 1'b0);

		$display("Errors: %0d testbench, %0d assertions", errors,
			pim_conv_top_i.pim_conv_sva_i.failures);
		if (errors == 0 && pim_conv_top_i.pim_conv_sva_i.failures == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
design/pim_data_pkg.sv
design/pim_ctrl_pkg.sv
design/bit_plane_counter.sv
design/input_bit_slicer.sv
design/weight_crossbar.sv
design/shift_accumulator.sv
design/pim_conv_fsm.sv
design/pim_conv_top.sv
testbench/tb_clock_gen.sv
testbench/pim_conv_sva.sv
testbench/pim_conv_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the PIM convolution testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f filelist.f --top-module pim_conv_tb \
	-o sim_pim_conv; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/sim_pim_conv +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Everything OK" sim.log; then
	exit 0
fi
exit 1
